// File: uart_pkg.sv
`default_nettype none

package uart_pkg;

  // width of the bit-period counters in tx and rx
  localparam int BIT_CNT_W = 16;

  // one data byte on the line
  typedef logic [7:0] byte_t;

  // command word, high byte goes out first
  typedef struct packed {
    byte_t hi;
    byte_t lo;
  } cmd_word_s;

  // receive result; err covers parity and stop faults
  typedef struct packed {
    logic  err;
    byte_t data;
  } rx_result_s;

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_PARITY,
    TX_STOP
  } tx_state_e;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rx_state_e;

  typedef enum logic [1:0] {
    FR_IDLE,
    FR_SEND_HI,
    FR_SEND_LO
  } framer_state_e;

endpackage

`default_nettype wire

// File: cmd_framer.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_framer (
  input  logic                clk,
  input  logic                rst_n,
  input  uart_pkg::cmd_word_s cmd_in,
  input  logic                cmd_vld,
  output logic                cmd_rdy,
  input  logic                free2,
  output logic                wr_en,
  output uart_pkg::byte_t     wr_data
);

  uart_pkg::framer_state_e state;
  uart_pkg::cmd_word_s     cmd_q;
  logic                    accept;

  // only take a word when both bytes fit
  assign cmd_rdy = (state == uart_pkg::FR_IDLE) && free2;
  assign accept  = cmd_vld && cmd_rdy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= uart_pkg::FR_IDLE;
    end else begin
      case (state)
        uart_pkg::FR_IDLE: begin
          if (accept) begin
            state <= uart_pkg::FR_SEND_HI;
          end
        end
        uart_pkg::FR_SEND_HI: begin
          state <= uart_pkg::FR_SEND_LO;
        end
        uart_pkg::FR_SEND_LO: begin
          state <= uart_pkg::FR_IDLE;
        end
        default: begin
          state <= uart_pkg::FR_IDLE;
        end
      endcase
    end
  end

  // word held while its two bytes go out
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd_in;
    end
  end

  assign wr_en   = (state == uart_pkg::FR_SEND_HI) || (state == uart_pkg::FR_SEND_LO);
  assign wr_data = (state == uart_pkg::FR_SEND_HI) ? cmd_q.hi : cmd_q.lo;

endmodule

`default_nettype wire

// File: byte_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module byte_fifo #(
  parameter int DEPTH = 4
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            wr_en,
  input  uart_pkg::byte_t wr_data,
  input  logic            rd_en,
  output uart_pkg::byte_t rd_data,
  output logic            empty,
  output logic            free2
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  uart_pkg::byte_t  mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // pointers wrap at DEPTH, so any depth works
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      case ({wr_en, rd_en})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // head entry shown without a read latency
  assign rd_data = mem[rd_ptr];
  assign empty   = (count == '0);
  assign free2   = (count <= CNT_W'(DEPTH - 2));

endmodule

`default_nettype wire

// File: uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
  parameter int CLKS_PER_BIT = 434,
  parameter int PARITY_EN    = 1
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            empty,
  input  uart_pkg::byte_t rd_data,
  output logic            rd_en,
  output logic            tx
);

  localparam int CW = uart_pkg::BIT_CNT_W;
  localparam logic [CW-1:0] LAST_CNT = CW'(CLKS_PER_BIT - 1);

  uart_pkg::tx_state_e state;
  logic [CW-1:0]       bit_cnt;
  logic [2:0]          bit_idx;
  uart_pkg::byte_t     shift;
  logic                par;
  logic                bit_done;

  assign bit_done = (bit_cnt == LAST_CNT);

  // load from idle, or back to back at the end of a stop bit
  assign rd_en = !empty && ((state == uart_pkg::TX_IDLE) ||
                            ((state == uart_pkg::TX_STOP) && bit_done));

  always_ff @(posedge clk) begin
    if (rd_en) begin
      shift <= rd_data;
      // xnor reduction gives odd parity
      par   <= ~^rd_data;
    end else if ((state == uart_pkg::TX_DATA) && bit_done) begin
      shift <= {1'b0, shift[7:1]};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= uart_pkg::TX_IDLE;
      bit_cnt <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;
    end else if (rd_en) begin
      state   <= uart_pkg::TX_START;
      bit_cnt <= '0;
      tx      <= 1'b0;
    end else if (state != uart_pkg::TX_IDLE) begin
      if (!bit_done) begin
        bit_cnt <= bit_cnt + 1'b1;
      end else begin
        bit_cnt <= '0;
        case (state)
          uart_pkg::TX_START: begin
            state   <= uart_pkg::TX_DATA;
            bit_idx <= '0;
            tx      <= shift[0];
          end
          uart_pkg::TX_DATA: begin
            if (bit_idx != 3'd7) begin
              bit_idx <= bit_idx + 1'b1;
              tx      <= shift[1];
            end else if (PARITY_EN != 0) begin
              state <= uart_pkg::TX_PARITY;
              tx    <= par;
            end else begin
              state <= uart_pkg::TX_STOP;
              tx    <= 1'b1;
            end
          end
          uart_pkg::TX_PARITY: begin
            state <= uart_pkg::TX_STOP;
            tx    <= 1'b1;
          end
          default: begin
            // stop bit done and nothing queued
            state <= uart_pkg::TX_IDLE;
            tx    <= 1'b1;
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
  parameter int CLKS_PER_BIT = 434,
  parameter int PARITY_EN    = 1
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 rx,
  output logic                 read_rdy,
  output uart_pkg::rx_result_s read_data
);

  localparam int CW = uart_pkg::BIT_CNT_W;
  localparam logic [CW-1:0] LAST_CNT = CW'(CLKS_PER_BIT - 1);
  localparam logic [CW-1:0] HALF_CNT = CW'(CLKS_PER_BIT / 2 - 1);

  uart_pkg::rx_state_e state;
  logic [CW-1:0]       bit_cnt;
  logic [2:0]          bit_idx;
  uart_pkg::byte_t     shift;
  logic                par_bit;
  logic                rx_meta;
  logic                rx_sync;
  logic                rx_prev;
  logic                fall;
  logic                bit_done;
  logic                half_done;
  logic                par_err;

  // two-flop synchronizer plus one more for edge detection
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign fall      = rx_prev && !rx_sync;
  assign bit_done  = (bit_cnt == LAST_CNT);
  assign half_done = (bit_cnt == HALF_CNT);
  // data plus parity must hold an odd number of ones
  assign par_err   = (PARITY_EN != 0) && !(^{shift, par_bit});

  always_ff @(posedge clk) begin
    if ((state == uart_pkg::RX_DATA) && bit_done) begin
      shift <= {rx_sync, shift[7:1]};
    end
    if ((state == uart_pkg::RX_PARITY) && bit_done) begin
      par_bit <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= uart_pkg::RX_IDLE;
      bit_cnt   <= '0;
      bit_idx   <= '0;
      read_rdy  <= 1'b0;
      read_data <= '0;
    end else begin
      read_rdy <= 1'b0;
      case (state)
        uart_pkg::RX_IDLE: begin
          bit_cnt <= '0;
          if (fall) begin
            state <= uart_pkg::RX_START;
          end
        end
        uart_pkg::RX_START: begin
          if (!half_done) begin
            bit_cnt <= bit_cnt + 1'b1;
          end else begin
            bit_cnt <= '0;
            bit_idx <= '0;
            // glitch, line back high at mid start
            if (rx_sync) begin
              state <= uart_pkg::RX_IDLE;
            end else begin
              state <= uart_pkg::RX_DATA;
            end
          end
        end
        uart_pkg::RX_DATA: begin
          if (!bit_done) begin
            bit_cnt <= bit_cnt + 1'b1;
          end else begin
            bit_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              if (PARITY_EN != 0) begin
                state <= uart_pkg::RX_PARITY;
              end else begin
                state <= uart_pkg::RX_STOP;
              end
            end
          end
        end
        uart_pkg::RX_PARITY: begin
          if (!bit_done) begin
            bit_cnt <= bit_cnt + 1'b1;
          end else begin
            bit_cnt <= '0;
            state   <= uart_pkg::RX_STOP;
          end
        end
        default: begin
          if (!bit_done) begin
            bit_cnt <= bit_cnt + 1'b1;
          end else begin
            bit_cnt        <= '0;
            state          <= uart_pkg::RX_IDLE;
            read_rdy       <= 1'b1;
            read_data.data <= shift;
            read_data.err  <= !rx_sync || par_err;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: uart_cmd_link.sv
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_link #(
  parameter int CLK_HZ     = 50_000_000,
  parameter int BAUD       = 115_200,
  parameter int PARITY_EN  = 1,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  uart_pkg::cmd_word_s  cmd_in,
  input  logic                 cmd_vld,
  output logic                 cmd_rdy,
  input  logic                 rx,
  output logic                 tx,
  output logic                 read_rdy,
  output uart_pkg::rx_result_s read_data
);

  // bit period in clocks, rounded to nearest
  localparam int CLKS_PER_BIT = (CLK_HZ + BAUD / 2) / BAUD;

  logic            wr_en;
  uart_pkg::byte_t wr_data;
  logic            free2;
  logic            empty;
  logic            rd_en;
  uart_pkg::byte_t rd_data;

  cmd_framer u_cmd_framer (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd_in  (cmd_in),
    .cmd_vld (cmd_vld),
    .cmd_rdy (cmd_rdy),
    .free2   (free2),
    .wr_en   (wr_en),
    .wr_data (wr_data)
  );

  byte_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) u_byte_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (wr_en),
    .wr_data (wr_data),
    .rd_en   (rd_en),
    .rd_data (rd_data),
    .empty   (empty),
    .free2   (free2)
  );

  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .PARITY_EN    (PARITY_EN)
  ) u_uart_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .empty   (empty),
    .rd_data (rd_data),
    .rd_en   (rd_en),
    .tx      (tx)
  );

  uart_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .PARITY_EN    (PARITY_EN)
  ) u_uart_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

endmodule

`default_nettype wire

// File: uart_cmd_link_sva.sv
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_link_sva (
  input logic                clk,
  input logic                rst_n,
  input logic                tx,
  input logic                read_rdy,
  input logic                cmd_vld,
  input logic                cmd_rdy,
  input logic                rd_en,
  input logic                empty,
  input uart_pkg::tx_state_e tx_state
);

  // idle line rests high
  a_tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
    (tx_state == uart_pkg::TX_IDLE) |-> tx)
    else $error("tx low while the transmitter is idle");

  a_read_rdy_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy)
    else $error("read_rdy high for more than one cycle");

  // framer busy right after an accept
  a_rdy_drop: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd_vld && cmd_rdy) |=> !cmd_rdy)
    else $error("cmd_rdy still high in the cycle after an accept");

  a_no_read_empty: assert property (@(posedge clk) disable iff (!rst_n)
    !(rd_en && empty))
    else $error("FIFO read while empty");

endmodule

bind uart_cmd_link uart_cmd_link_sva u_uart_cmd_link_sva (
  .clk      (clk),
  .rst_n    (rst_n),
  .tx       (tx),
  .read_rdy (read_rdy),
  .cmd_vld  (cmd_vld),
  .cmd_rdy  (cmd_rdy),
  .rd_en    (rd_en),
  .empty    (empty),
  .tx_state (u_uart_tx.state)
);

`default_nettype wire

// File: tb_uart_cmd_link.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_cmd_link;

  localparam int N_RAND   = 20;
  localparam int N_GEN    = 6;
  localparam int BIT_CLKS = 8;
  localparam int N_FRAMES = 2 + 2 * N_RAND + N_GEN;
  // twice the line time of every frame plus margin for gaps
  localparam int WATCHDOG_NS = 2 * N_FRAMES * 11 * BIT_CLKS * 4 + 4000;

  logic                 clk;
  logic                 rst_n;
  uart_pkg::cmd_word_s  cmd_in;
  logic                 cmd_vld;
  logic                 cmd_rdy;
  logic                 rx;
  logic                 tx;
  logic                 read_rdy;
  uart_pkg::rx_result_s read_data;
  logic                 loopback;
  logic                 gen_line;

  uart_pkg::byte_t      exp_q[$];
  uart_pkg::byte_t      got_q[$];
  logic [1:0]           got_ps_q[$];
  uart_pkg::rx_result_s rd_exp_q[$];
  int                   tx_errs;
  int                   rd_errs;
  int                   misc_errs;
  int                   stall_cycles;
  int                   since_accept;

  // rx from tx loopback or from the frame generator
  assign rx = loopback ? tx : gen_line;

  uart_cmd_link #(
    .CLK_HZ     (1_000_000),
    .BAUD       (125_000),
    .PARITY_EN  (1),
    .FIFO_DEPTH (4)
  ) u_uart_cmd_link (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

  // {parity, stop}; ones in byte plus parity must be odd
  function automatic logic [1:0] expected_frame(input uart_pkg::byte_t b);
    logic p;
    p = 1'b1;
    for (int i = 0; i < 8; i++) begin
      p = p ^ b[i];
    end
    return {p, 1'b1};
  endfunction

  function automatic uart_pkg::rx_result_s make_result(input logic e, input uart_pkg::byte_t b);
    uart_pkg::rx_result_s r;
    r.err  = e;
    r.data = b;
    return r;
  endfunction

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // tx decoder samples near each bit center
  always begin
    uart_pkg::byte_t b;
    logic            p;
    logic            s;
    @(negedge tx);
    repeat (BIT_CLKS / 2) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      repeat (BIT_CLKS) @(negedge clk);
      b[i] = tx;
    end
    repeat (BIT_CLKS) @(negedge clk);
    p = tx;
    repeat (BIT_CLKS) @(negedge clk);
    s = tx;
    got_q.push_back(b);
    got_ps_q.push_back({p, s});
  end

  // accepted commands
  always @(posedge clk) begin
    if (rst_n && cmd_vld && cmd_rdy) begin
      exp_q.push_back(cmd_in.hi);
      exp_q.push_back(cmd_in.lo);
      if (loopback) begin
        rd_exp_q.push_back(make_result(1'b0, cmd_in.hi));
        rd_exp_q.push_back(make_result(1'b0, cmd_in.lo));
      end
      since_accept = 0;
    end else begin
      // stalls past the framer's two busy cycles come from back-pressure
      if (rst_n && cmd_vld && !cmd_rdy && since_accept >= 2) begin
        stall_cycles++;
      end
      since_accept++;
    end
  end

  // tx frame compare
  always @(negedge clk) begin
    uart_pkg::byte_t b;
    uart_pkg::byte_t e;
    logic [1:0]      ps;
    if (got_q.size() != 0) begin
      b  = got_q.pop_front();
      ps = got_ps_q.pop_front();
      if (exp_q.size() == 0) begin
        $display("ERROR: frame with byte %02h on tx at %0t that no command asked for", b, $time);
        misc_errs++;
      end else begin
        e = exp_q.pop_front();
        if (b !== e) begin
          $display("CHECK FAILED @ %0t ns: tx byte %02h, expected %02h", $time, b, e);
          tx_errs++;
        end
        if (ps !== expected_frame(e)) begin
          $display("CHECK FAILED @ %0t ns: tx parity/stop %02b, expected %02b",
                   $time, ps, expected_frame(e));
          tx_errs++;
        end
      end
    end
  end

  // read result compare
  always @(negedge clk) begin
    uart_pkg::rx_result_s r;
    if (read_rdy) begin
      if (rd_exp_q.size() == 0) begin
        $display("ERROR: read_rdy pulse at %0t with no read expected", $time);
        misc_errs++;
      end else begin
        r = rd_exp_q.pop_front();
        if (read_data !== r) begin
          $display("CHECK FAILED @ %0t ns: read err=%0b data=%02h, expected err=%0b data=%02h",
                   $time, read_data.err, read_data.data, r.err, r.data);
          rd_errs++;
        end
      end
    end
  end

  task automatic drive_cmd(input uart_pkg::cmd_word_s c);
    @(negedge clk);
    cmd_in  = c;
    cmd_vld = 1'b1;
    while (!cmd_rdy) begin
      @(negedge clk);
    end
    @(negedge clk);
    cmd_vld = 1'b0;
  endtask

  task automatic send_frame(input uart_pkg::byte_t b, input logic bad_par, input logic bad_stop);
    logic [1:0]  ps;
    logic [10:0] bits;
    ps   = expected_frame(b);
    bits = {ps[0] ^ bad_stop, ps[1] ^ bad_par, b, 1'b0};
    rd_exp_q.push_back(make_result(bad_par || bad_stop, b));
    for (int i = 0; i < 11; i++) begin
      @(negedge clk);
      gen_line = bits[i];
      repeat (BIT_CLKS - 1) @(negedge clk);
    end
    @(negedge clk);
    gen_line = 1'b1;
    repeat (2 * BIT_CLKS) @(negedge clk);
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0 || rd_exp_q.size() != 0 || got_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (2 * BIT_CLKS) @(negedge clk);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    uart_pkg::cmd_word_s c;
    void'($urandom(79025));
    tx_errs      = 0;
    rd_errs      = 0;
    misc_errs    = 0;
    stall_cycles = 0;
    since_accept = 0;
    rst_n        = 1'b0;
    cmd_in       = '0;
    cmd_vld      = 1'b0;
    loopback     = 1'b1;
    gen_line     = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    if (tx !== 1'b1 || cmd_rdy !== 1'b1 || read_rdy !== 1'b0) begin
      $display("CHECK FAILED @ %0t ns: after reset tx=%b cmd_rdy=%b read_rdy=%b, expected 1 1 0",
               $time, tx, cmd_rdy, read_rdy);
      misc_errs++;
    end
    // one command then a random burst with loopback reads
    c.hi = 8'hC3;
    c.lo = 8'h5A;
    drive_cmd(c);
    wait_drain();
    for (int n = 0; n < N_RAND; n++) begin
      c.hi = 8'($urandom);
      c.lo = 8'($urandom);
      repeat ($urandom_range(0, 3)) @(negedge clk);
      drive_cmd(c);
    end
    wait_drain();
    if (stall_cycles == 0) begin
      $display("ERROR: cmd_rdy never dropped under FIFO back-pressure");
      misc_errs++;
    end
    // good and corrupted generator frames
    loopback = 1'b0;
    send_frame(8'h00, 1'b0, 1'b0);
    send_frame(8'hFF, 1'b0, 1'b0);
    send_frame(8'($urandom), 1'b0, 1'b0);
    send_frame(8'h3C, 1'b1, 1'b0);
    send_frame(8'hA7, 1'b0, 1'b1);
    send_frame(8'h81, 1'b1, 1'b1);
    wait_drain();
    $display("errors: tx %0d, read %0d, other %0d", tx_errs, rd_errs, misc_errs);
    if (tx_errs + rd_errs + misc_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
uart_pkg.sv
cmd_framer.sv
byte_fifo.sv
uart_tx.sv
uart_rx.sv
uart_cmd_link.sv
uart_cmd_link_sva.sv
tb_uart_cmd_link.sv

// File: run.sh
#!/bin/sh
# compile and run the UART command link testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f verilog.f --top-module tb_uart_cmd_link -o sim_tb

out=$(./obj_dir/sim_tb) || true
echo "$out"

if echo "$out" | grep -qx "PASS: all tests"; then
  exit 0
else
  exit 1
fi
